//--- logic/periph_defs.svh
`ifndef PERIPH_DEFS_SVH
`define PERIPH_DEFS_SVH

// Bus widths
`define PERIPH_ADDR_W     11
`define PERIPH_DATA_W     32

// Slot map
`define PERIPH_NUM_USER   24   // Full interface slots
`define PERIPH_NUM_SIMPLE 16   // Byte interface slots
`define PERIPH_SLOT_GPIO  1
`define PERIPH_SLOT_PWM   4

// GPIO register offsets within the 64 byte slot
`define GPIO_REG_OUT      6'h00
`define GPIO_REG_IN       6'h04
`define GPIO_REG_AUDIO    6'h10
`define GPIO_REG_FUNC     6'h20   // Pin n select lives at 0x20 + 4*n
`define GPIO_FUNC_MASK    6'h23   // Keeps bit 5 and the byte lane bits

// Reset and source codes
`define GPIO_FUNC_RESET   6'h01   // User slot 1, the GPIO register itself
`define AUDIO_SRC_PWM     3'd2

// PWM register offset within the 16 byte slot
`define PWM_REG_DUTY      4'h0

`endif

//--- logic/periph_pkg.sv
package periph_pkg;

    // Request size code from the core, also used as the idle marker
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10,
        SIZE_NONE = 2'b11   // No access this cycle
    } access_size_e;

    typedef struct packed {
        logic [10:0]  addr;
        logic [31:0]  wdata;     // Low 8, 16 or 32 bits valid on write
        access_size_e write_n;
        access_size_e read_n;
    } bus_req_t;

    // Decoded slot, one region at a time
    typedef struct packed {
        logic       is_simple;
        logic [4:0] user_index;
        logic [3:0] simple_index;
    } slot_sel_t;

    typedef enum logic {
        RD_IDLE = 1'b0,
        RD_HOLD = 1'b1
    } rd_state_e;

    // Per-pin output source, same bit layout as the function select register
    typedef struct packed {
        logic       from_user_hi;   // Adds 16 to the user index
        logic       is_simple;
        logic [3:0] index;
    } func_sel_t;

endpackage

//--- logic/periph_addr_decode.sv
`timescale 1ns/100ps
`include "periph_defs.svh"

module periph_addr_decode (
    input  periph_pkg::bus_req_t  i_req,
    input  logic [`PERIPH_DATA_W-1:0] i_gpio_rdata,
    input  logic [7:0]            i_pwm_rdata,
    output periph_pkg::slot_sel_t o_sel,
    output logic                  o_gpio_sel,
    output logic                  o_pwm_sel,
    output logic [`PERIPH_DATA_W-1:0] o_rdata,
    output logic                  o_rdata_ready
);

    logic [`PERIPH_NUM_USER-1:0]   user_hit;
    logic [`PERIPH_NUM_SIMPLE-1:0] simple_hit;

    // Region decode from the upper address bits
    always_comb begin
        o_sel = '0;
        if (i_req.addr[10:9] == 2'b10) begin
            o_sel.is_simple    = 1'b1;            // 16 bytes per byte slot
            o_sel.simple_index = i_req.addr[7:4];
        end else if (i_req.addr[10]) begin
            o_sel.user_index = {2'b10, i_req.addr[8:6]};   // Slots 16 to 23
        end else begin
            o_sel.user_index = {1'b0, i_req.addr[9:6]};
        end
    end

    always_comb begin
        user_hit   = '0;
        simple_hit = '0;
        if (o_sel.is_simple) simple_hit[o_sel.simple_index] = 1'b1;
        else                 user_hit[o_sel.user_index]     = 1'b1;
    end

    assign o_gpio_sel = user_hit[`PERIPH_SLOT_GPIO];
    assign o_pwm_sel  = simple_hit[`PERIPH_SLOT_PWM];

    // Unpopulated slots fall through to zero
    always_comb begin
        o_rdata = '0;
        if (o_pwm_sel)       o_rdata = `PERIPH_DATA_W'(i_pwm_rdata);   // Byte slot, zero-extended
        else if (o_gpio_sel) o_rdata = i_gpio_rdata;
    end

    // Every slot answers in the same cycle, empty ones included
    assign o_rdata_ready = 1'b1;

    always_comb begin
        assert (!(o_gpio_sel && o_pwm_sel))
            else $error("GPIO and PWM slots selected together");
    end

endmodule

//--- logic/read_response_ctrl.sv
`timescale 1ns/100ps

module read_response_ctrl (
    input  logic                     clk,
    input  logic                     rst_n,
    input  periph_pkg::access_size_e i_read_n,
    input  periph_pkg::access_size_e i_write_n,
    input  logic [31:0]              i_rdata,
    input  logic                     i_rdata_ready,
    input  logic                     i_read_complete,
    output logic [31:0]              o_data,
    output logic                     o_data_ready
);

    periph_pkg::rd_state_e state;

    logic        rd_req;
    logic        wr_req;
    logic        capture;
    logic        ready_r;
    logic [31:0] data_r;

    assign rd_req  = (i_read_n != periph_pkg::SIZE_NONE);
    assign wr_req  = (i_write_n != periph_pkg::SIZE_NONE);
    assign capture = (state == periph_pkg::RD_IDLE) && rd_req && i_rdata_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= periph_pkg::RD_IDLE;
            ready_r <= 1'b0;
        end else begin
            // Ready is registered to line up with the captured data
            ready_r <= rd_req && i_rdata_ready;

            case (state)
                periph_pkg::RD_IDLE: begin
                    if (capture) state <= periph_pkg::RD_HOLD;
                end
                periph_pkg::RD_HOLD: begin
                    // Complete and a new request together still go back to idle,
                    // the new read is captured one edge later
                    if (i_read_complete) state <= periph_pkg::RD_IDLE;
                end
                default: state <= periph_pkg::RD_IDLE;
            endcase
        end
    end

    // Held until the core has taken it, whatever the slot does meanwhile
    always_ff @(posedge clk) begin
        if (capture) data_r <= i_rdata;
    end

    assign o_data       = data_r;
    assign o_data_ready = ready_r || wr_req;   // Writes are acknowledged at once

    assert property (@(posedge clk) disable iff (!rst_n)
        (state == periph_pkg::RD_HOLD && !i_read_complete) |=> $stable(o_data))
        else $error("Read data changed while held");

endmodule

//--- logic/gpio_config.sv
`timescale 1ns/100ps
`include "periph_defs.svh"

module gpio_config (
    input  logic                 clk,
    input  logic                 rst_n,
    input  periph_pkg::bus_req_t i_req,
    input  logic                 i_sel,
    input  logic [7:0]           i_ui_in,
    input  logic [7:0]           i_pwm_pins,
    output logic [`PERIPH_DATA_W-1:0] o_rdata,
    output logic [7:0]           o_uo_out,
    output logic                 o_audio,
    output logic                 o_audio_select
);

    periph_pkg::func_sel_t func_sel [8];

    logic [5:0] offset;
    logic       wr_en;
    logic       is_func;
    logic [7:0] gpio_out;
    logic [3:0] audio_sel;     // Bit 3 routes audio to the pin, bits 2:0 pick the source
    logic [7:0] pin_out;

    assign offset  = i_req.addr[5:0];
    assign wr_en   = i_sel && (i_req.write_n != periph_pkg::SIZE_NONE);
    assign is_func = ((offset & `GPIO_FUNC_MASK) == `GPIO_REG_FUNC);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out  <= '0;
            audio_sel <= '0;
        end else if (wr_en) begin
            if (offset == `GPIO_REG_OUT)   gpio_out  <= i_req.wdata[7:0];
            if (offset == `GPIO_REG_AUDIO) audio_sel <= i_req.wdata[3:0];
        end
    end

    // All pins start on the GPIO register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int p = 0; p < 8; p++) begin
                func_sel[p] <= periph_pkg::func_sel_t'(`GPIO_FUNC_RESET);
            end
        end else if (wr_en && is_func) begin
            func_sel[offset[4:2]] <= periph_pkg::func_sel_t'(i_req.wdata[5:0]);
        end
    end

    // Each pin takes its own bit position from the chosen slot
    always_comb begin
        for (int p = 0; p < 8; p++) begin
            pin_out[p] = 1'b0;
            if (func_sel[p].is_simple) begin
                if (func_sel[p].index == 4'(`PERIPH_SLOT_PWM)) pin_out[p] = i_pwm_pins[p];
            end else if ({func_sel[p].from_user_hi, func_sel[p].index} ==
                         5'(`PERIPH_SLOT_GPIO)) begin
                pin_out[p] = gpio_out[p];
            end
        end
    end

    assign o_uo_out = pin_out;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            o_audio <= 1'b0;
        end else begin
            // Only the PWM source is populated
            o_audio <= (audio_sel[2:0] == `AUDIO_SRC_PWM) ? i_pwm_pins[0] : 1'b0;
        end
    end

    assign o_audio_select = audio_sel[3];

    always_comb begin
        o_rdata = '0;
        if (offset == `GPIO_REG_OUT) begin
            o_rdata = `PERIPH_DATA_W'(gpio_out);
        end else if (offset == `GPIO_REG_IN) begin
            o_rdata = `PERIPH_DATA_W'(i_ui_in);
        end else if (offset == `GPIO_REG_AUDIO) begin
            o_rdata = `PERIPH_DATA_W'(audio_sel);
        end else if (is_func) begin
            o_rdata = `PERIPH_DATA_W'(func_sel[offset[4:2]]);   // Pin number from bits 4:2
        end
    end

    assert property (@(posedge clk) !rst_n |=> !o_audio_select)
        else $error("Audio select not cleared by reset");

endmodule

//--- logic/pwm_timer.sv
`timescale 1ns/100ps
`include "periph_defs.svh"

module pwm_timer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  periph_pkg::bus_req_t i_req,
    input  logic                 i_sel,
    output logic [7:0]           o_rdata,
    output logic [7:0]           o_pins
);

    logic [3:0] offset;
    logic       wr_duty;
    logic [7:0] count;
    logic [7:0] duty;
    logic       pwm_hi;

    // Byte slot, only the low nibble of the address is ours
    assign offset  = i_req.addr[3:0];
    assign wr_duty = i_sel && (i_req.write_n != periph_pkg::SIZE_NONE) &&
                     (offset == `PWM_REG_DUTY);

    // Free running, wraps every 256 cycles
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            count <= count + 8'd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            duty <= '0;
        end else if (wr_duty) begin
            duty <= i_req.wdata[7:0];
        end
    end

    // Duty of 0 never drives high, 255 drives high all but one cycle
    assign pwm_hi = (count < duty);

    assign o_pins  = {8{pwm_hi}};
    assign o_rdata = (offset == `PWM_REG_DUTY) ? duty : 8'h00;

endmodule

//--- logic/periph_bus_top.sv
`timescale 1ns/100ps
`include "periph_defs.svh"

module periph_bus_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  periph_pkg::bus_req_t i_req,
    input  logic [7:0]           i_ui_in,
    input  logic                 i_read_complete,
    output logic [`PERIPH_DATA_W-1:0] o_data,
    output logic                 o_data_ready,
    output logic [7:0]           o_uo_out,
    output logic                 o_audio,
    output logic                 o_audio_select
);

    logic                      gpio_sel;
    logic                      pwm_sel;
    logic [`PERIPH_DATA_W-1:0] gpio_rdata;
    logic [7:0]                pwm_rdata;
    logic [`PERIPH_DATA_W-1:0] slot_rdata;
    logic                      slot_ready;
    logic [7:0]                pwm_pins;

    periph_addr_decode i_periph_addr_decode (
        .i_req         (i_req),
        .i_gpio_rdata  (gpio_rdata),
        .i_pwm_rdata   (pwm_rdata),
        .o_sel         (),
        .o_gpio_sel    (gpio_sel),
        .o_pwm_sel     (pwm_sel),
        .o_rdata       (slot_rdata),
        .o_rdata_ready (slot_ready)
    );

    read_response_ctrl i_read_response_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_req.read_n),
        .i_write_n       (i_req.write_n),
        .i_rdata         (slot_rdata),
        .i_rdata_ready   (slot_ready),
        .i_read_complete (i_read_complete),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready)
    );

    gpio_config i_gpio_config (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_req          (i_req),
        .i_sel          (gpio_sel),
        .i_ui_in        (i_ui_in),
        .i_pwm_pins     (pwm_pins),
        .o_rdata        (gpio_rdata),
        .o_uo_out       (o_uo_out),
        .o_audio        (o_audio),
        .o_audio_select (o_audio_select)
    );

    pwm_timer i_pwm_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_req   (i_req),
        .i_sel   (pwm_sel),
        .o_rdata (pwm_rdata),
        .o_pins  (pwm_pins)
    );

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/100ps

module tb_clock_gen (
    output logic o_clk,
    output logic o_rst_n
);

    localparam int HALF_PERIOD  = 10;   // 20 ns clock
    localparam int RESET_CYCLES = 10;

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // Release on a falling edge, away from the sampling edge
    initial begin
        o_rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_rst_n <= 1'b1;
    end

endmodule

//--- verification/periph_bus_tb.sv
`timescale 1ns/100ps
`include "periph_defs.svh"

module periph_bus_tb;

    localparam int          CLK_PERIOD    = 20;
    localparam int          WINDOW        = 256;                    // One PWM period
    localparam int          TEST_CYCLES   = 10 + 4 * WINDOW + 200;  // Reset, four windows, bus traffic
    localparam logic [31:0] SEED          = 32'h8895_190f;
    localparam logic [10:0] GPIO_BASE     = 11'(`PERIPH_SLOT_GPIO << 6);
    localparam logic [10:0] PWM_ADDR      = 11'h400 + 11'(`PERIPH_SLOT_PWM << 4);
    localparam logic [10:0] EMPTY_ADDR    = 11'h000;                // Unpopulated user slot 0
    localparam logic [10:0] GPIO_OUT_ADDR = GPIO_BASE + 11'(`GPIO_REG_OUT);
    localparam logic [10:0] GPIO_IN_ADDR  = GPIO_BASE + 11'(`GPIO_REG_IN);
    localparam logic [10:0] AUDIO_ADDR    = GPIO_BASE + 11'(`GPIO_REG_AUDIO);
    localparam logic [10:0] FUNC_ADDR     = GPIO_BASE + 11'(`GPIO_REG_FUNC);

    logic                 clk;
    logic                 rst_n;
    periph_pkg::bus_req_t i_req;
    logic [7:0]           i_ui_in;
    logic                 i_read_complete;
    logic [31:0]          o_data;
    logic                 o_data_ready;
    logic [7:0]           o_uo_out;
    logic                 o_audio;
    logic                 o_audio_select;

    // Expected values follow the stimulus
    logic        exp_ready;
    logic [31:0] exp_data;
    logic        chk_data;     // No read captured before the first read
    logic [7:0]  exp_uo;
    logic [7:0]  uo_mask;      // Pins routed to PWM drop out of the compare
    logic        exp_asel;
    logic [31:0] rng_state;
    string       test_name;

    tb_clock_gen i_tb_clock_gen (.o_clk(clk), .o_rst_n(rst_n));

    periph_bus_top i_periph_bus_top (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_req           (i_req),
        .i_ui_in         (i_ui_in),
        .i_read_complete (i_read_complete),
        .o_data          (o_data),
        .o_data_ready    (o_data_ready),
        .o_uo_out        (o_uo_out),
        .o_audio         (o_audio),
        .o_audio_select  (o_audio_select)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s ^ (s << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic fail_now();
        $display("Checks failed");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic report_mismatch(input string what, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        $display("Error: test %s, %s expected 0x%0h actual 0x%0h",
                 test_name, what, exp_val, act_val);
        fail_now();
    endtask

    // Outputs sampled mid cycle before the next stimulus lands
    assert property (@(negedge clk) disable iff (!rst_n) o_data_ready == exp_ready)
        else report_mismatch("o_data_ready", 32'(exp_ready), 32'(o_data_ready));
    assert property (@(negedge clk) disable iff (!rst_n) !chk_data || o_data == exp_data)
        else report_mismatch("o_data", exp_data, o_data);
    assert property (@(negedge clk) disable iff (!rst_n) o_audio_select == exp_asel)
        else report_mismatch("o_audio_select", 32'(exp_asel), 32'(o_audio_select));
    assert property (@(negedge clk) disable iff (!rst_n)
        (o_uo_out & uo_mask) == (exp_uo & uo_mask))
        else report_mismatch("o_uo_out", 32'(exp_uo & uo_mask), 32'(o_uo_out & uo_mask));

    // Write acknowledged in its own cycle and mirrored into the GPIO expectations
    task automatic bus_write(input logic [10:0] address, input logic [31:0] data,
                             input periph_pkg::access_size_e size);
        @(negedge clk);
        i_req <= '{addr: address, wdata: data, write_n: size, read_n: periph_pkg::SIZE_NONE};
        exp_ready <= 1'b1;
        if (address == GPIO_OUT_ADDR) exp_uo <= data[7:0];
        if (address == AUDIO_ADDR) exp_asel <= data[3];
        if ((address & 11'h7E3) == FUNC_ADDR) begin
            uo_mask[address[4:2]] <= (data[5:0] == 6'(`GPIO_FUNC_RESET));
        end
        @(negedge clk);
        i_req.write_n <= periph_pkg::SIZE_NONE;
        exp_ready <= 1'b0;
    endtask

    // Ready and data come one cycle after the request and the core then releases it
    task automatic bus_read(input logic [10:0] address, input logic [31:0] expected);
        @(negedge clk);
        i_req <= '{addr: address, wdata: '0, write_n: periph_pkg::SIZE_NONE,
                   read_n: periph_pkg::SIZE_WORD};
        exp_ready <= 1'b1;
        exp_data  <= expected;
        chk_data  <= 1'b1;
        @(negedge clk);
        i_req.read_n    <= periph_pkg::SIZE_NONE;
        i_read_complete <= 1'b1;
        exp_ready       <= 1'b0;
        @(negedge clk);
        i_read_complete <= 1'b0;
    endtask

    task automatic count_high(input logic use_audio, input int pin, output int n);
        n = 0;
        repeat (WINDOW) begin
            @(negedge clk);
            if (use_audio ? o_audio : o_uo_out[pin]) n++;
        end
    endtask

    initial begin
        #(TEST_CYCLES * 2 * CLK_PERIOD);
        $display("Timeout: the tests did not finish within %0d cycles", 2 * TEST_CYCLES);
        fail_now();
    end

    initial begin
        logic [31:0] rnd;
        logic [7:0]  gpio_val;
        logic [7:0]  ui_a;
        logic [7:0]  duty_a;
        int          pin;
        int          n;
        i_req = '{addr: '0, wdata: '0, write_n: periph_pkg::SIZE_NONE,
                  read_n: periph_pkg::SIZE_NONE};
        i_ui_in         = 8'h00;
        i_read_complete = 1'b0;
        exp_ready       = 1'b0;
        exp_data        = '0;
        chk_data        = 1'b0;
        exp_uo          = 8'h00;
        uo_mask         = 8'hFF;
        exp_asel        = 1'b0;
        rng_state       = SEED;

        test_name = "reset";
        @(posedge rst_n);
        repeat (8) @(negedge clk);   // Ready must stay low on an idle bus

        test_name = "gpio output";
        rnd = next_rand();
        gpio_val = rnd[7:0];
        bus_write(GPIO_OUT_ADDR, 32'(gpio_val), periph_pkg::SIZE_WORD);
        bus_read(GPIO_OUT_ADDR, 32'(gpio_val));
        rnd = next_rand();
        ui_a = rnd[7:0];
        i_ui_in <= ui_a;
        bus_read(GPIO_IN_ADDR, 32'(ui_a));

        test_name = "read hold";
        rnd = next_rand();
        ui_a = rnd[7:0];
        i_ui_in <= ui_a;
        @(negedge clk);
        i_req <= '{addr: GPIO_IN_ADDR, wdata: '0, write_n: periph_pkg::SIZE_NONE,
                   read_n: periph_pkg::SIZE_WORD};
        exp_ready <= 1'b1;
        exp_data  <= 32'(ui_a);
        @(negedge clk);
        i_req.addr <= EMPTY_ADDR;   // Captured data must not follow the source away
        i_ui_in    <= ~ui_a;
        repeat (4) @(negedge clk);
        i_read_complete <= 1'b1;
        @(negedge clk);
        i_read_complete <= 1'b0;
        exp_data        <= 32'h0;   // Empty slot captured on the following edge
        @(negedge clk);
        i_req.read_n    <= periph_pkg::SIZE_NONE;
        i_read_complete <= 1'b1;
        exp_ready       <= 1'b0;
        @(negedge clk);
        i_read_complete <= 1'b0;

        test_name = "pin routing";
        rnd = next_rand();
        pin = int'(rnd[2:0]);
        bus_write(FUNC_ADDR + 11'(4 * pin), 32'h14, periph_pkg::SIZE_WORD);
        bus_read(FUNC_ADDR + 11'(4 * pin), 32'h14);
        bus_write(PWM_ADDR, 32'h00, periph_pkg::SIZE_BYTE);
        bus_read(PWM_ADDR, 32'h00);
        count_high(1'b0, pin, n);
        assert (n == 0) else report_mismatch("pin high count at duty 0", 32'd0, 32'(n));
        bus_write(PWM_ADDR, 32'hFF, periph_pkg::SIZE_BYTE);
        bus_read(PWM_ADDR, 32'hFF);
        count_high(1'b0, pin, n);
        assert (n == 255) else report_mismatch("pin high count at duty 255", 32'd255, 32'(n));
        rnd = next_rand();
        bus_write(GPIO_OUT_ADDR, 32'(rnd[7:0]), periph_pkg::SIZE_WORD);
        repeat (2) @(negedge clk);

        test_name = "audio";
        bus_write(AUDIO_ADDR, 32'hA, periph_pkg::SIZE_WORD);
        rnd = next_rand();
        duty_a = rnd[7:0];
        bus_write(PWM_ADDR, 32'(duty_a), periph_pkg::SIZE_BYTE);
        bus_read(AUDIO_ADDR, 32'hA);
        count_high(1'b1, 0, n);
        assert (n == int'(duty_a)) else report_mismatch("audio high count", 32'(duty_a), 32'(n));
        bus_write(AUDIO_ADDR, 32'h3, periph_pkg::SIZE_WORD);
        @(negedge clk);   // Audio output lags its source by one cycle
        count_high(1'b1, 0, n);
        assert (n == 0) else report_mismatch("audio high count when off", 32'd0, 32'(n));

        test_name = "end";
        repeat (4) @(negedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

//--- src.f
+incdir+logic
logic/periph_pkg.sv
logic/periph_addr_decode.sv
logic/read_response_ctrl.sv
logic/gpio_config.sv
logic/pwm_timer.sv
logic/periph_bus_top.sv
verification/tb_clock_gen.sv
verification/periph_bus_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f src.f --top-module periph_bus_tb -o periph_bus_sim

# Output is shown on the terminal and searched for the pass line
if ./obj_dir/periph_bus_sim | tee /dev/stderr | grep -F "All checks passed" > /dev/null; then
    exit 0
fi
exit 1
